// File: sim/sprite_data.mem
// one 8-bit bitmap row per line in hex, msb is the leftmost pixel
// lines 0-7 are sprite 0 rows 0-7, lines 8-15 are sprite 1 rows 0-7
3C
7E
DB
FF
FF
BD
42
3C
18
3C
7E
FF
FF
7E
3C
18

// File: filelist.f
common/sprite_pkg.sv
hdl/display_timing.sv
sprite/sprite_arbiter.sv
sprite/sprite_rom.sv
sprite/sprite_engine.sv
hdl/pixel_compositor.sv
hdl/sprite_display_top.sv
sim/sprite_display_tb.sv

// File: run.sh
#!/bin/sh
# build and run the sprite display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --timescale 1ns/10ps \
    --top-module sprite_display_tb \
    -f filelist.f

# rom and testbench load sim/sprite_data.mem relative to the project root
out=$(./obj_dir/Vsprite_display_tb)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Test passed"

// File: sim/sprite_display_tb.sv
// *********************************************************************
// testbench for the sprite display: rebuilds screen coordinates from
// the video outputs and checks every pixel against a reference model
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module sprite_display_tb;

    localparam int unsigned SEED = 32'h145ba20c;
    localparam int FRAME_CYCLES = sprite_pkg::H_TOTAL * sprite_pkg::V_TOTAL;  // 420000
    localparam int PLANNED_FRAMES = 9;  // reset frame plus 8 more
    localparam real TIMEOUT_NS = PLANNED_FRAMES * FRAME_CYCLES * 20.0 * 1.5;

    logic clk_pix;
    logic arst_n;
    logic [sprite_pkg::CORDW-1:0] spr0_x, spr0_y, spr1_x, spr1_y;
    logic vga_hsync, vga_vsync, vga_de;
    logic [3:0] vga_r, vga_g, vga_b;

    logic [sprite_pkg::SPR_W-1:0] bitmap [sprite_pkg::SPR_COUNT * sprite_pkg::SPR_H];

    // coordinates and timing rebuilt from the outputs
    int cyc = 0;
    int last_hs_fall = -1;       // none seen yet
    int hs_low = 0;
    int lines_in_frame = 0;      // hsync falls between vsync falls
    int vs_lines = 0;            // hsync falls while vsync low
    int act_lines = 0;           // y, counted from end of vsync
    int px = 0;                  // x, de-high pixels in this line
    int frame_idx = 0;           // 0 is the frame right after reset
    bit seen_vs_fall = 1'b0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    logic prev_de = 1'b0;
    int ax0 = 0, ay0 = 0, ax1 = 0, ay1 = 0;  // positions of the current frame

    int err_count = 0;
    int err_mark = 0;
    int test_num = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    sprite_display_top sprite_display_top_inst (
        .clk_pix,
        .arst_n,
        .spr0_x,
        .spr0_y,
        .spr1_x,
        .spr1_y,
        .vga_hsync,
        .vga_vsync,
        .vga_de,
        .vga_r,
        .vga_g,
        .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz stand-in for the pixel clock
    end

    initial begin
        $readmemh("sim/sprite_data.mem", bitmap);
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("Error %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    // bitmap lookup, 0 outside the 8x8 box
    function automatic bit sprite_bit(input int n, input int col, input int row);
        if (col < 0 || col >= sprite_pkg::SPR_W || row < 0 || row >= sprite_pkg::SPR_H)
            return 1'b0;
        return bitmap[n * sprite_pkg::SPR_H + row][sprite_pkg::SPR_W - 1 - col];
    endfunction

    // sprite 0 on top of sprite 1 on top of background
    function automatic logic [11:0] expected_pixel(input int x, input int y,
            input int px0, input int py0, input int px1, input int py1);
        if (sprite_bit(0, x - px0, y - py0))
            return {sprite_pkg::SPR0_R, sprite_pkg::SPR0_G, sprite_pkg::SPR0_B};
        if (sprite_bit(1, x - px1, y - py1))
            return {sprite_pkg::SPR1_R, sprite_pkg::SPR1_G, sprite_pkg::SPR1_B};
        return {sprite_pkg::BG_R, sprite_pkg::BG_G, sprite_pkg::BG_B};
    endfunction

    // compare process, outputs are stable on the falling edge
    always @(negedge clk_pix) begin
        if (arst_n) begin
            cyc++;
            if (prev_hs && !vga_hsync) begin
                if (last_hs_fall >= 0)
                    compare_value("hsync period", sprite_pkg::H_TOTAL, cyc - last_hs_fall);
                last_hs_fall = cyc;
                lines_in_frame++;
                if (!vga_vsync)
                    vs_lines++;
            end
            if (!vga_hsync) begin
                hs_low++;
            end else if (!prev_hs) begin
                compare_value("hsync low", sprite_pkg::H_SYNC, hs_low);
                hs_low = 0;
            end
            if (vga_de) begin
                if (frame_idx >= 1)  // frame 0 starts before any row fetch
                    compare_value("vga_r/vga_g/vga_b",
                                  expected_pixel(px, act_lines, ax0, ay0, ax1, ay1),
                                  {vga_r, vga_g, vga_b});
                px++;
            end else begin
                if (prev_de) begin
                    compare_value("de high", sprite_pkg::H_RES, px);
                    act_lines++;
                    px = 0;
                end
                compare_value("vga_r/vga_g/vga_b", 12'h000, {vga_r, vga_g, vga_b});
            end
            if (prev_vs && !vga_vsync) begin
                if (seen_vs_fall)
                    compare_value("frame lines", sprite_pkg::V_TOTAL, lines_in_frame);
                seen_vs_fall = 1'b1;
                lines_in_frame = 0;
                vs_lines = 0;
            end else if (!prev_vs && vga_vsync) begin
                compare_value("vsync lines", sprite_pkg::V_SYNC, vs_lines);
                compare_value("active lines", sprite_pkg::V_RES, act_lines);
                act_lines = 0;
                // positions were latched at the frame strobe, inputs quiet since
                ax0 = spr0_x;
                ay0 = spr0_y;
                ax1 = spr1_x;
                ay1 = spr1_y;
                frame_idx++;
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            prev_de = vga_de;
        end
    end

    task automatic check_idle_outputs();
        compare_value("vga_hsync", 1, vga_hsync);
        compare_value("vga_vsync", 1, vga_vsync);
        compare_value("vga_de", 0, vga_de);
        compare_value("vga_r/vga_g/vga_b", 0, {vga_r, vga_g, vga_b});
    endtask

    task automatic finish_test(input string name);
        int n;
        n = err_count - err_mark;
        test_num++;
        if (n == 0) begin
            tests_ok++;
            $display("test %0d, %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d, %s: %0d mismatches", test_num, name, n);
        end
        err_mark = err_count;
    endtask

    task automatic wait_frame(input int n);
        while (frame_idx < n)
            @(negedge clk_pix);
    endtask

    // change positions halfway down the active area
    task automatic drive_mid_frame(input int x0, input int y0, input int x1, input int y1);
        while (!(vga_de && act_lines >= sprite_pkg::V_RES / 2))
            @(negedge clk_pix);
        spr0_x = sprite_pkg::CORDW'(x0);
        spr0_y = sprite_pkg::CORDW'(y0);
        spr1_x = sprite_pkg::CORDW'(x1);
        spr1_y = sprite_pkg::CORDW'(y1);
    endtask

    // sprite 0 in the left half, sprite 1 in the right half
    task automatic pick_separated(output int x0, output int y0, output int x1, output int y1);
        x0 = $urandom_range(0, 312);
        x1 = $urandom_range(320, sprite_pkg::H_RES - sprite_pkg::SPR_W);
        y0 = $urandom_range(0, sprite_pkg::V_RES - sprite_pkg::SPR_H);
        y1 = $urandom_range(0, sprite_pkg::V_RES - sprite_pkg::SPR_H);
    endtask

    initial begin : stimulus
        int x0, y0, x1, y1;
        void'($urandom(SEED));
        arst_n = 1'b0;
        spr0_x = '0;
        spr0_y = '0;
        spr1_x = '0;
        spr1_y = '0;
        repeat (4) @(negedge clk_pix);
        check_idle_outputs();
        @(negedge clk_pix);
        arst_n = 1'b1;  // 5 cycles low
        @(negedge clk_pix);
        check_idle_outputs();  // pipeline still empty
        finish_test("reset state");

        wait_frame(1);
        pick_separated(x0, y0, x1, y1);
        drive_mid_frame(x0, y0, x1, y1);
        wait_frame(2);
        finish_test("sync timing");

        pick_separated(x0, y0, x1, y1);
        drive_mid_frame(x0, y0, x1, y1);  // frame 3
        wait_frame(3);
        x0 = $urandom_range(0, 600);
        y0 = $urandom_range(0, 440);
        drive_mid_frame(x0, y0, x0 + 3, y0 + 2);  // overlap shows in frame 4
        wait_frame(4);
        finish_test("separated sprites");

        drive_mid_frame(636, 476, 0, 0);
        wait_frame(5);
        finish_test("overlap priority");

        pick_separated(x0, y0, x1, y1);
        drive_mid_frame(x0, y0, x1, y1);
        wait_frame(6);
        finish_test("edge clipping");

        // swap sides mid frame 6, frame 7 must follow
        y0 = $urandom_range(sprite_pkg::V_RES / 2 + sprite_pkg::SPR_H,
                            sprite_pkg::V_RES - sprite_pkg::SPR_H);  // rows below the switch
        y1 = $urandom_range(sprite_pkg::V_RES / 2 + sprite_pkg::SPR_H,
                            sprite_pkg::V_RES - sprite_pkg::SPR_H);
        drive_mid_frame(x1, y0, x0, y1);
        wait_frame(8);
        finish_test("position update");

        $display("%0d tests ok, %0d tests with mismatches, %0d mismatches in total",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("run timed out before all frames were checked");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/sprite_display_top.sv
// *********************************************************************
// sprite display top: timing, two sprite engines sharing one rom via
// the arbiter, and the compositor driving the video outputs
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module sprite_display_top (
    input  wire logic clk_pix,   // 640x480 pixel clock
    input  wire logic arst_n,
    input  wire logic [sprite_pkg::CORDW-1:0] spr0_x,
    input  wire logic [sprite_pkg::CORDW-1:0] spr0_y,
    input  wire logic [sprite_pkg::CORDW-1:0] spr1_x,
    input  wire logic [sprite_pkg::CORDW-1:0] spr1_y,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic vga_de,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    // timing
    logic [sprite_pkg::CORDW-1:0] sx, sy;
    logic hsync, vsync, de, line, frame;

    // rom access
    logic req0, req1, gnt0, gnt1;
    logic [sprite_pkg::ROM_AW-1:0] addr0, addr1, rom_addr;
    logic [sprite_pkg::SPR_W-1:0] rom_data;  // shared by both engines

    logic pix0, pix1;

    display_timing display_timing_inst (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .line,
        .frame
    );

    sprite_engine #(.SPR_ID(0)) sprite_engine_0_inst (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .line,
        .frame,
        .pos_x    (spr0_x),
        .pos_y    (spr0_y),
        .rom_req  (req0),
        .rom_addr (addr0),
        .rom_gnt  (gnt0),
        .rom_data,
        .pix      (pix0)
    );

    sprite_engine #(.SPR_ID(1)) sprite_engine_1_inst (
        .clk_pix,
        .arst_n,
        .sx,
        .sy,
        .line,
        .frame,
        .pos_x    (spr1_x),
        .pos_y    (spr1_y),
        .rom_req  (req1),
        .rom_addr (addr1),
        .rom_gnt  (gnt1),
        .rom_data,
        .pix      (pix1)
    );

    sprite_arbiter sprite_arbiter_inst (
        .clk_pix,
        .arst_n,
        .req0,
        .req1,
        .addr0,
        .addr1,
        .gnt0,
        .gnt1,
        .rom_addr
    );

    sprite_rom sprite_rom_inst (
        .clk_pix,
        .addr (rom_addr),
        .data (rom_data)
    );

    pixel_compositor pixel_compositor_inst (
        .clk_pix,
        .arst_n,
        .hsync,
        .vsync,
        .de,
        .pix0,
        .pix1,
        .vga_hsync,
        .vga_vsync,
        .vga_de,
        .vga_r,
        .vga_g,
        .vga_b
    );

endmodule

`default_nettype wire

// File: hdl/pixel_compositor.sv
// *********************************************************************
// mixes the two sprite pixels, sprite 0 on top, applies the palette
// and registers colour and syncs so they leave in step
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module pixel_compositor (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic hsync,
    input  wire logic vsync,
    input  wire logic de,
    input  wire logic pix0,   // already one cycle behind the counters
    input  wire logic pix1,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic vga_de,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    logic hsync_d, vsync_d, de_d;  // lined up with pix0/pix1

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync_d   <= 1'b1;  // inactive
            vsync_d   <= 1'b1;
            de_d      <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= 4'h0;
            vga_g     <= 4'h0;
            vga_b     <= 4'h0;
        end else begin
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            de_d      <= de;
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            if (!de_d) begin
                // blanking must be black
                {vga_r, vga_g, vga_b} <= 12'h000;
            end else if (pix0) begin
                {vga_r, vga_g, vga_b} <= {sprite_pkg::SPR0_R, sprite_pkg::SPR0_G,
                                          sprite_pkg::SPR0_B};
            end else if (pix1) begin
                {vga_r, vga_g, vga_b} <= {sprite_pkg::SPR1_R, sprite_pkg::SPR1_G,
                                          sprite_pkg::SPR1_B};
            end else begin
                {vga_r, vga_g, vga_b} <= {sprite_pkg::BG_R, sprite_pkg::BG_G,
                                          sprite_pkg::BG_B};
            end
        end
    end

endmodule

`default_nettype wire

// File: sprite/sprite_engine.sv
// *********************************************************************
// one 8x8 one-bit sprite: latches its position each frame, fetches
// the row for the coming line from the shared rom, then shifts it out
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module sprite_engine #(
    parameter int SPR_ID = 0  // selects the rom region
) (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic [sprite_pkg::CORDW-1:0] sx,
    input  wire logic [sprite_pkg::CORDW-1:0] sy,
    input  wire logic line,
    input  wire logic frame,
    input  wire logic [sprite_pkg::CORDW-1:0] pos_x,  // left column
    input  wire logic [sprite_pkg::CORDW-1:0] pos_y,  // top line
    output logic rom_req,                              // held until gnt
    output logic [sprite_pkg::ROM_AW-1:0] rom_addr,
    input  wire logic rom_gnt,                         // one-cycle pulse
    input  wire logic [sprite_pkg::SPR_W-1:0] rom_data,
    output logic pix                                   // one cycle after sx
);

    sprite_pkg::engine_state_t state;

    logic [sprite_pkg::CORDW-1:0] pos_x_r, pos_y_r;  // frame positions
    logic [sprite_pkg::CORDW-1:0] next_y;            // line announced by line
    logic [sprite_pkg::CORDW-1:0] row;               // row within sprite
    logic row_hit;
    logic draw_now;
    logic [sprite_pkg::SPR_W-1:0] bits;              // row shift register
    logic [$clog2(sprite_pkg::SPR_W):0] cnt;         // pixels drawn, 0..8

    // positions only change between frames
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pos_x_r <= '0;
            pos_y_r <= '0;
        end else if (frame) begin
            pos_x_r <= pos_x;
            pos_y_r <= pos_y;
        end
    end

    always_comb begin
        // line after the last one wraps to the top
        if (sy == sprite_pkg::CORDW'(sprite_pkg::V_TOTAL - 1))
            next_y = '0;
        else
            next_y = sy + 1'b1;
        row     = next_y - pos_y_r;  // only meaningful when next_y >= pos_y_r
        row_hit = (next_y >= pos_y_r) && (row < sprite_pkg::SPR_H) &&
                  (next_y < sprite_pkg::V_RES);
        // first pixel at pos_x, then until 8 done or right edge
        draw_now = (sx < sprite_pkg::H_RES) &&
                   ((state == sprite_pkg::ST_ARMED && sx == pos_x_r) ||
                    (state == sprite_pkg::ST_DRAW && cnt < sprite_pkg::SPR_W));
        rom_req  = (state == sprite_pkg::ST_REQ);
    end

    // row address and bitmap
    always_ff @(posedge clk_pix) begin
        if (line)
            rom_addr <= sprite_pkg::ROM_AW'(SPR_ID * sprite_pkg::SPR_H) +
                        sprite_pkg::ROM_AW'(row);
        if (state == sprite_pkg::ST_WAIT)
            bits <= rom_data;  // rom answers one cycle after grant
        else if (draw_now)
            bits <= bits << 1;  // msb first
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= sprite_pkg::ST_IDLE;
            cnt   <= '0;
            pix   <= 1'b0;
        end else begin
            pix <= draw_now ? bits[sprite_pkg::SPR_W-1] : 1'b0;
            if (line) begin
                // new line decision overrides whatever is left
                state <= row_hit ? sprite_pkg::ST_REQ : sprite_pkg::ST_IDLE;
            end else begin
                case (state)
                    sprite_pkg::ST_REQ:
                        if (rom_gnt) state <= sprite_pkg::ST_WAIT;
                    sprite_pkg::ST_WAIT:
                        state <= sprite_pkg::ST_ARMED;
                    sprite_pkg::ST_ARMED:
                        if (draw_now) begin
                            cnt   <= 1'b1;  // first pixel goes out now
                            state <= sprite_pkg::ST_DRAW;
                        end
                    sprite_pkg::ST_DRAW:
                        if (draw_now)
                            cnt <= cnt + 1'b1;
                        else
                            state <= sprite_pkg::ST_IDLE;  // done or clipped
                    default:
                        state <= sprite_pkg::ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: sprite/sprite_rom.sv
// *********************************************************************
// sprite bitmap rom, one 8-bit row per word, loaded from hex at start;
// registered read gives one cycle of latency
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module sprite_rom (
    input  wire logic clk_pix,
    input  wire logic [sprite_pkg::ROM_AW-1:0] addr,
    output logic [sprite_pkg::SPR_W-1:0] data
);

    logic [sprite_pkg::SPR_W-1:0] mem [sprite_pkg::SPR_COUNT * sprite_pkg::SPR_H];

    initial begin
        $readmemh("sim/sprite_data.mem", mem);  // path relative to run dir
    end

    always_ff @(posedge clk_pix) begin
        data <= mem[addr];
    end

endmodule

`default_nettype wire

// File: sprite/sprite_arbiter.sv
// *********************************************************************
// round-robin access to the sprite rom for the two engines; grant is
// a single cycle and steers the rom address from the granted engine
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module sprite_arbiter (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic req0,
    input  wire logic req1,
    input  wire logic [sprite_pkg::ROM_AW-1:0] addr0,
    input  wire logic [sprite_pkg::ROM_AW-1:0] addr1,
    output logic gnt0,
    output logic gnt1,
    output logic [sprite_pkg::ROM_AW-1:0] rom_addr
);

    logic last1;  // last grant went to engine 1

    // at most one grant, never to an idle engine
    always_comb begin
        gnt0     = req0 && (!req1 || last1);
        gnt1     = req1 && (!req0 || !last1);
        rom_addr = gnt1 ? addr1 : addr0;  // addr0 when idle, harmless
    end

    // engine drops req the cycle after gnt, so gnt stays a pulse
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n)
            last1 <= 1'b1;  // engine 0 wins the first tie
        else if (gnt0)
            last1 <= 1'b0;
        else if (gnt1)
            last1 <= 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/display_timing.sv
// *********************************************************************
// 640x480 display timing: screen counters, active low syncs, data
// enable, plus one-cycle strobes at hblank start and vblank start
// *********************************************************************

`default_nettype none
`timescale 1ns/10ps

module display_timing (
    input  wire logic clk_pix,   // pixel clock
    input  wire logic arst_n,    // async reset, active low
    output logic [sprite_pkg::CORDW-1:0] sx,  // 0..799
    output logic [sprite_pkg::CORDW-1:0] sy,  // 0..524
    output logic hsync,          // active low
    output logic vsync,          // active low
    output logic de,             // active area
    output logic line,           // start of hblank, next line announced
    output logic frame           // start of vblank
);

    // pixel and line counters
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == sprite_pkg::CORDW'(sprite_pkg::H_TOTAL - 1)) begin
            sx <= '0;  // end of line
            if (sy == sprite_pkg::CORDW'(sprite_pkg::V_TOTAL - 1))
                sy <= '0;  // end of frame
            else
                sy <= sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode straight from the counters, one cycle ahead of the pixels
    always_comb begin
        hsync = !(sx >= (sprite_pkg::H_RES + sprite_pkg::H_FP) &&
                  sx <  (sprite_pkg::H_RES + sprite_pkg::H_FP + sprite_pkg::H_SYNC));
        vsync = !(sy >= (sprite_pkg::V_RES + sprite_pkg::V_FP) &&
                  sy <  (sprite_pkg::V_RES + sprite_pkg::V_FP + sprite_pkg::V_SYNC));
        de    = (sx < sprite_pkg::H_RES) && (sy < sprite_pkg::V_RES);
        line  = (sx == sprite_pkg::CORDW'(sprite_pkg::H_RES));  // also in vblank
        frame = (sx == '0) && (sy == sprite_pkg::CORDW'(sprite_pkg::V_RES));
    end

endmodule

`default_nettype wire

// File: common/sprite_pkg.sv
// *********************************************************************
// shared constants for the sprite display: 640x480 timing, sprite
// geometry, rom layout, palette and the sprite engine state type
// *********************************************************************

`default_nettype none

package sprite_pkg;

    // horizontal timing in pixels
    localparam int H_RES   = 640;  // active
    localparam int H_FP    = 16;   // front porch
    localparam int H_SYNC  = 96;   // sync pulse
    localparam int H_BP    = 48;   // back porch
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_RES   = 480;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    localparam int CORDW = 16;  // coordinate width, unsigned

    // sprite bitmaps, one rom word per row, msb is leftmost
    localparam int SPR_W     = 8;
    localparam int SPR_H     = 8;
    localparam int SPR_COUNT = 2;
    localparam int ROM_AW    = 4;  // sprite n row r at n*SPR_H + r

    // palette, 4 bits per channel
    localparam logic [3:0] SPR0_R = 4'hF;  // orange
    localparam logic [3:0] SPR0_G = 4'hC;
    localparam logic [3:0] SPR0_B = 4'h0;
    localparam logic [3:0] SPR1_R = 4'h2;  // light blue
    localparam logic [3:0] SPR1_G = 4'h8;
    localparam logic [3:0] SPR1_B = 4'hF;
    localparam logic [3:0] BG_R   = 4'h0;  // dark navy background
    localparam logic [3:0] BG_G   = 4'h0;
    localparam logic [3:0] BG_B   = 4'h4;

    // sprite engine fsm
    typedef enum logic [2:0] {
        ST_IDLE,   // nothing to draw on this line
        ST_REQ,    // waiting for rom grant
        ST_WAIT,   // rom data arrives this cycle
        ST_ARMED,  // row loaded, waiting for sx to reach pos_x
        ST_DRAW    // shifting pixels out
    } engine_state_t;

endpackage

`default_nettype wire
